// File: hw/sdram_pkg.sv
/*
 * SDRAM device description for a x16 SDR part with 4 banks, 8192 rows and
 * 1024 columns: command encodings, timing counts at 20 MHz, field types
 */
package sdram_pkg;

    typedef logic [12:0] dram_addr_t;   // Multiplexed row / column address bus
    typedef logic [1:0]  dram_bank_t;
    typedef logic [9:0]  dram_col_t;
    typedef logic [15:0] dram_data_t;   // DQ word

    // Command word is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } dram_cmd_t;

    localparam int INIT_WAIT_CYCLES = 2000;   // 100 us power-up wait
    localparam int T_RP             = 2;      // Precharge to next command
    localparam int T_RC             = 7;      // Refresh recovery, also ACTIVE to ACTIVE
    localparam int T_RCD            = 2;      // ACTIVE to READ / WRITE
    localparam int T_WR             = 2;      // Write recovery before auto-precharge
    localparam int CAS_LATENCY      = 2;
    localparam int REFRESH_INTERVAL = 156;    // 64 ms / 8192 rows
    localparam int A10_PRECHARGE    = 10;     // Auto-precharge / precharge-all bit

    // Burst length 1, sequential, CAS 2, standard op, single-location write
    localparam dram_addr_t MODE_REG = 13'b000_1_00_010_0_000;

    // Counter widths derived from the timing above
    localparam int INIT_COUNT_W    = $clog2(INIT_WAIT_CYCLES + 1);
    localparam int RC_COUNT_W      = $clog2(T_RC + 2);
    localparam int STEP_W          = $clog2(T_RCD + T_WR + CAS_LATENCY + T_RP + 1);
    localparam int REFRESH_COUNT_W = $clog2(2 * REFRESH_INTERVAL);

endpackage

// File: hw/mem_access_pkg.sv
/*
 * Processor-side access description: byte address, data word, access size
 * and the number of 16-bit words one access touches
 */
package mem_access_pkg;

    // {bank[25:24], row[23:11], column[10:1], byte in word[0]}
    typedef logic [25:0] byte_addr_t;
    typedef logic [63:0] access_data_t;   // Right-aligned payload
    typedef logic [2:0]  word_count_t;    // 1 to 5 words

    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } access_size_t;

endpackage

// File: hw/sdram_init.sv
/*
 * Power-up sequencer: start-up wait, precharge-all, two auto-refreshes and a
 * mode register load, then a single done pulse
 */
`timescale 1ns/1ns

module sdram_init (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    output logic                   done,
    output sdram_pkg::dram_cmd_t   cmd,
    output sdram_pkg::dram_addr_t  dram_addr,
    output sdram_pkg::dram_bank_t  dram_ba
);
    import sdram_pkg::*;

    typedef enum logic [2:0] {
        S_WAIT, S_PRECHARGE, S_REFRESH1, S_REFRESH2, S_LOAD_MODE, S_DONE, S_FINISHED
    } init_state_t;

    init_state_t             state;
    logic [INIT_COUNT_W-1:0] count;       // Cycles spent in the current step
    logic [INIT_COUNT_W-1:0] dwell;       // Length of the current step
    logic                    done_seen;   // Sticky, set by the first done

    // Each step issues its command in its first cycle, then pads with NOP
    always_comb begin
        case (state)
            S_WAIT:                 dwell = INIT_COUNT_W'(INIT_WAIT_CYCLES);
            S_PRECHARGE:            dwell = INIT_COUNT_W'(T_RP + 1);
            S_REFRESH1, S_REFRESH2: dwell = INIT_COUNT_W'(T_RC);
            S_LOAD_MODE:            dwell = INIT_COUNT_W'(2);   // Mode register set time
            default:                dwell = INIT_COUNT_W'(1);
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= S_WAIT;
            count <= '0;
        end else if (enable && state != S_FINISHED) begin
            if (count == dwell - 1'b1) begin
                count <= '0;
                state <= init_state_t'(state + 1'b1);   // Steps run in enum order
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_comb begin
        cmd       = CMD_NOP;
        dram_addr = '0;
        dram_ba   = '0;   // Mode register lives behind bank 0
        if (enable && count == '0) begin
            case (state)
                S_PRECHARGE: begin
                    cmd                      = CMD_PRECHARGE;
                    dram_addr[A10_PRECHARGE] = 1'b1;   // All banks
                end
                S_REFRESH1, S_REFRESH2: cmd = CMD_REFRESH;
                S_LOAD_MODE: begin
                    cmd       = CMD_LOAD_MODE;
                    dram_addr = MODE_REG;
                end
                default: cmd = CMD_NOP;
            endcase
        end
    end

    assign done = enable && state == S_DONE;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            done_seen <= 1'b0;
        else if (done)
            done_seen <= 1'b1;
    end

    // Initialization runs exactly once per reset
    a_single_done: assert property (@(posedge clock) disable iff (reset)
        done |-> !done_seen);

endmodule

// File: hw/sdram_refresh.sv
/*
 * One auto-refresh cycle: REFRESH on entry, T_RC of recovery, then done
 */
`timescale 1ns/1ns

module sdram_refresh (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  enable,
    output logic                  done,
    output sdram_pkg::dram_cmd_t  cmd
);
    import sdram_pkg::*;

    logic [RC_COUNT_W-1:0] count;   // Cycles since the REFRESH command

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            count <= '0;
        else if (!enable)
            count <= '0;             // Rearm for the next interval
        else
            count <= count + 1'b1;
    end

    assign cmd  = (enable && count == '0) ? CMD_REFRESH : CMD_NOP;
    assign done = enable && count == RC_COUNT_W'(T_RC);

endmodule

// File: hw/sdram_read_write.sv
/*
 * Access sequencer: splits one access into 16-bit single accesses, each
 * ACTIVE then READ / WRITE with auto-precharge, masks byte lanes with DQM
 * and gathers read bytes right-aligned
 */
`timescale 1ns/1ns

module sdram_read_write (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           rd_enable,
    input  logic                           wr_enable,
    input  sdram_pkg::dram_bank_t          start_bank,
    input  sdram_pkg::dram_addr_t          start_row,
    input  sdram_pkg::dram_col_t           start_col,
    input  logic                           byte_offset,
    input  mem_access_pkg::access_size_t   size,
    input  mem_access_pkg::word_count_t    word_count,
    input  mem_access_pkg::access_data_t   write_data,
    output logic                           done,
    output mem_access_pkg::access_data_t   read_data,
    output sdram_pkg::dram_cmd_t           cmd,
    output sdram_pkg::dram_addr_t          dram_addr,
    output sdram_pkg::dram_bank_t          dram_ba,
    output logic                           dram_ldqm,
    output logic                           dram_udqm,
    inout  wire sdram_pkg::dram_data_t     dram_dq
);
    import sdram_pkg::*;
    import mem_access_pkg::*;

    logic              active;
    logic [STEP_W-1:0] step;        // Cycle within the current word
    logic [STEP_W-1:0] last_step;
    word_count_t       word_idx;
    dram_col_t         col;
    logic              first_word;
    logic              last_word;
    logic              sample;      // Read data on DQ this cycle
    logic [2:0]        byte_ptr;    // Next free byte of the gather buffer
    access_data_t      gather;

    assign active = rd_enable | wr_enable;

    // Word period covers precharge recovery, which also meets T_RC
    assign last_step  = wr_enable ? STEP_W'(T_RCD + T_WR + T_RP)
                                  : STEP_W'(T_RCD + CAS_LATENCY + T_RP);
    assign first_word = word_idx == '0;
    assign last_word  = word_idx == word_count - 1'b1;
    assign col        = start_col + dram_col_t'(word_idx);   // Wraps inside the row
    assign sample     = rd_enable && step == STEP_W'(T_RCD + CAS_LATENCY);
    assign done       = active && last_word && step == last_step;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            step     <= '0;
            word_idx <= '0;
        end else if (!active || done) begin
            step     <= '0;
            word_idx <= '0;
        end else if (step == last_step) begin
            step     <= '0;
            word_idx <= word_idx + 1'b1;
        end else begin
            step <= step + 1'b1;
        end
    end

    always_comb begin
        cmd       = CMD_NOP;
        dram_addr = '0;
        dram_ba   = '0;
        if (active) begin
            dram_ba = start_bank;
            if (step == '0) begin
                cmd       = CMD_ACTIVE;
                dram_addr = start_row;
            end else if (step == STEP_W'(T_RCD)) begin
                cmd                      = wr_enable ? CMD_WRITE : CMD_READ;
                dram_addr                = dram_addr_t'(col);
                dram_addr[A10_PRECHARGE] = 1'b1;   // Auto-precharge
            end
        end
    end

    // Low lane skipped on an odd start, high lane skipped when the span ends mid-word
    assign dram_ldqm = !active || (first_word && byte_offset);
    assign dram_udqm = !active || (last_word && (byte_offset ^ (size == SIZE_BYTE)));

    // Word 4 reuses lane 0, where the odd-address rotation left byte 7
    assign dram_dq = (wr_enable && step == STEP_W'(T_RCD)) ?
                     write_data[16 * word_idx[1:0] +: 16] : 'z;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            byte_ptr <= '0;
        else if (!active)
            byte_ptr <= '0;
        else if (sample)
            byte_ptr <= byte_ptr + 3'(!dram_ldqm) + 3'(!dram_udqm);
    end

    // Kept lanes pack downward, so the result is right-aligned and zero-filled
    always_ff @(posedge clock) begin
        if (!active) begin
            gather <= '0;
        end else if (sample) begin
            if (!dram_ldqm)
                gather[8 * byte_ptr +: 8] <= dram_dq[7:0];
            if (!dram_udqm)
                gather[8 * (byte_ptr + 3'(!dram_ldqm)) +: 8] <= dram_dq[15:8];
        end
    end

    always_ff @(posedge clock) begin
        if (done && rd_enable)
            read_data <= gather;   // Holds until the next read ends
    end

    // Column command never closer than T_RCD to its ACTIVE
    a_rcd: assert property (@(posedge clock) disable iff (reset)
        cmd == CMD_ACTIVE |=> (cmd != CMD_READ && cmd != CMD_WRITE) [* (T_RCD - 1)]);

endmodule

// File: hw/sdram_controller.sv
/*
 * SDRAM controller top: mode FSM over init, refresh and access sequencers,
 * refresh interval timer, request latch and the command bus multiplexer
 */
`timescale 1ns/1ns

module sdram_controller (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          rd_enable,
    input  logic                          wr_enable,
    input  mem_access_pkg::byte_addr_t    address,
    input  mem_access_pkg::access_size_t  size,
    input  mem_access_pkg::access_data_t  write_data,
    output logic                          busy,
    output mem_access_pkg::access_data_t  read_data,
    output logic                          dram_clk,
    output logic                          dram_cke,
    output sdram_pkg::dram_addr_t         dram_addr,
    output sdram_pkg::dram_bank_t         dram_ba,
    output logic                          dram_cs_n,
    output logic                          dram_ras_n,
    output logic                          dram_cas_n,
    output logic                          dram_we_n,
    output logic                          dram_ldqm,
    output logic                          dram_udqm,
    inout  wire sdram_pkg::dram_data_t    dram_dq
);
    import sdram_pkg::*;
    import mem_access_pkg::*;

    typedef enum logic [1:0] {MODE_INIT, MODE_IDLE, MODE_ACCESS, MODE_REFRESH} mode_t;

    mode_t                      mode;
    mode_t                      mode_next;
    logic                       accept;         // Strobe taken this cycle
    logic                       req_rd;
    logic                       req_wr;
    byte_addr_t                 req_addr;
    access_size_t               req_size;
    access_data_t               req_data;
    logic [REFRESH_COUNT_W-1:0] refresh_count;
    logic                       refresh_due;
    logic [3:0]                 span_bytes;     // Byte offset plus access size
    word_count_t                word_count;
    access_data_t               aligned_data;
    logic                       init_done;
    logic                       ref_done;
    logic                       rw_done;
    dram_cmd_t                  init_cmd;
    dram_cmd_t                  ref_cmd;
    dram_cmd_t                  rw_cmd;
    dram_cmd_t                  cmd;
    dram_addr_t                 init_addr;
    dram_addr_t                 rw_addr;
    dram_bank_t                 init_ba;
    dram_bank_t                 rw_ba;

    assign accept = (rd_enable | wr_enable) && !busy;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= 1'b0;
            req_rd <= 1'b0;
            req_wr <= 1'b0;
        end else if (rw_done) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy   <= 1'b1;
            req_rd <= rd_enable;
            req_wr <= wr_enable;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr <= address;
            req_size <= size;
            req_data <= write_data;
        end
    end

    assign span_bytes = 4'(req_addr[0]) + (4'd1 << req_size);
    assign word_count = word_count_t'((span_bytes + 4'd1) >> 1);   // Round up to words
    // Odd start puts byte 0 in the high lane, rotation keeps byte 7 for word 4
    assign aligned_data = req_addr[0] ? {req_data[55:0], req_data[63:56]} : req_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            refresh_count <= '0;
        else if (mode == MODE_INIT || mode == MODE_REFRESH)
            refresh_count <= '0;
        else
            refresh_count <= refresh_count + 1'b1;   // Runs through accesses too
    end

    assign refresh_due = refresh_count >= REFRESH_COUNT_W'(REFRESH_INTERVAL);

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            mode <= MODE_INIT;
        else
            mode <= mode_next;
    end

    always_comb begin
        mode_next = mode;
        case (mode)
            MODE_INIT:    if (init_done) mode_next = MODE_IDLE;
            MODE_IDLE: begin
                if (refresh_due)
                    mode_next = MODE_REFRESH;   // Refresh wins over a waiting request
                else if (busy || accept)
                    mode_next = MODE_ACCESS;
            end
            MODE_ACCESS:  if (rw_done) mode_next = MODE_IDLE;
            MODE_REFRESH: if (ref_done) mode_next = MODE_IDLE;
            default:      mode_next = MODE_IDLE;
        endcase
    end

    sdram_init u_init (
        .clock(clock), .reset(reset), .enable(mode == MODE_INIT), .done(init_done),
        .cmd(init_cmd), .dram_addr(init_addr), .dram_ba(init_ba)
    );

    sdram_refresh u_refresh (
        .clock(clock), .reset(reset), .enable(mode == MODE_REFRESH),
        .done(ref_done), .cmd(ref_cmd)
    );

    sdram_read_write u_read_write (
        .clock(clock), .reset(reset),
        .rd_enable(mode == MODE_ACCESS && req_rd),
        .wr_enable(mode == MODE_ACCESS && req_wr),
        .start_bank(req_addr[25:24]), .start_row(req_addr[23:11]),
        .start_col(req_addr[10:1]), .byte_offset(req_addr[0]),
        .size(req_size), .word_count(word_count), .write_data(aligned_data),
        .done(rw_done), .read_data(read_data), .cmd(rw_cmd),
        .dram_addr(rw_addr), .dram_ba(rw_ba),
        .dram_ldqm(dram_ldqm), .dram_udqm(dram_udqm), .dram_dq(dram_dq)
    );

    // Pin bus owner follows the mode
    always_comb begin
        case (mode)
            MODE_INIT: begin
                cmd       = init_cmd;
                dram_addr = init_addr;
                dram_ba   = init_ba;
            end
            MODE_ACCESS: begin
                cmd       = rw_cmd;
                dram_addr = rw_addr;
                dram_ba   = rw_ba;
            end
            MODE_REFRESH: begin
                cmd       = ref_cmd;
                dram_addr = '0;
                dram_ba   = '0;
            end
            default: begin
                cmd       = CMD_NOP;
                dram_addr = '0;
                dram_ba   = '0;
            end
        endcase
    end

    assign {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} = cmd;
    assign dram_cke = 1'b1;
    assign dram_clk = ~clock;   // Pins settle half a cycle before the device edge

    a_one_strobe: assert property (@(posedge clock) disable iff (reset)
        !(rd_enable && wr_enable));

    // An access ends only through the sequencer
    a_busy_fall: assert property (@(posedge clock) disable iff (reset)
        $fell(busy) |-> $past(rw_done));

endmodule

// File: test/sdram_model.sv
/*
 * Behavioral x16 SDR SDRAM: decodes commands on the rising device clock,
 * stores words sparsely and flags protocol and timing violations
 */
`timescale 1ns/1ns

module sdram_model (
    input  logic                       dram_clk,
    input  logic                       dram_cke,
    input  sdram_pkg::dram_addr_t      dram_addr,
    input  sdram_pkg::dram_bank_t      dram_ba,
    input  logic                       dram_cs_n,
    input  logic                       dram_ras_n,
    input  logic                       dram_cas_n,
    input  logic                       dram_we_n,
    input  logic                       dram_ldqm,
    input  logic                       dram_udqm,
    inout  wire sdram_pkg::dram_data_t dram_dq,
    output logic                       initialized,
    output logic                       fault
);
    import sdram_pkg::*;

    // Worst gap is one interval, the refresh itself and a five-word access
    localparam int REFRESH_LIMIT = REFRESH_INTERVAL + T_RC + 2 + 5 * (T_RCD + T_WR + T_RP + 1);

    dram_cmd_t   cmd;
    dram_data_t  mem [int unsigned];                 // Sparse, keyed by {bank, row, col}
    int unsigned cyc = 0;                            // Device clock count
    int unsigned last_refresh = 0;
    int unsigned bank_ready [4] = '{default: 0};     // Earliest cycle for the next ACTIVE
    int unsigned active_at [4] = '{default: 0};
    logic        bank_open [4] = '{default: 1'b0};
    dram_addr_t  open_row [4] = '{default: '0};
    int          init_step = 0;                      // Power-up commands seen so far
    logic        init_seen = 1'b0;
    logic        flagged = 1'b0;
    logic        rd_pending = 1'b0;
    int          rd_wait = 0;
    dram_data_t  rd_word = '0;
    dram_data_t  dq_out = '0;
    logic        dq_oe = 1'b0;
    int unsigned key;
    dram_data_t  word;

    assign cmd         = dram_cmd_t'({dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n});
    assign dram_dq     = dq_oe ? dq_out : 'z;
    assign initialized = init_seen;
    assign fault       = flagged;

    // Unwritten words read back as a pattern of their address
    function automatic dram_data_t fill_word(int unsigned addr_key);
        return dram_data_t'(addr_key ^ (addr_key >> 16));
    endfunction

    function automatic logic banks_idle(int unsigned now);
        logic idle;
        idle = 1'b1;
        for (int b = 0; b < 4; b++)
            if (bank_open[b] || now < bank_ready[b])
                idle = 1'b0;
        return idle;
    endfunction

    task automatic flag(input string what);
        $display("SDRAM model: %s at device cycle %0d", what, cyc);
        flagged = 1'b1;
    endtask

    always @(posedge dram_clk) begin
        dq_oe <= 1'b0;   // A read word stays on DQ for one device cycle
        if (rd_pending) begin
            if (rd_wait == 0) begin
                dq_oe      <= 1'b1;
                dq_out     <= rd_word;
                rd_pending <= 1'b0;
            end else begin
                rd_wait <= rd_wait - 1;
            end
        end
        if (init_seen) begin
            assert (dram_cke) else flag("clock enable dropped in service");
            assert (cyc - last_refresh <= REFRESH_LIMIT) else flag("refresh came too late");
        end
        // Deselect and unknown chip select are both ignored
        if (dram_cs_n === 1'b0 && cmd != CMD_NOP) begin
            if (!init_seen) begin
                case (init_step)
                    0:       assert (cmd == CMD_PRECHARGE && dram_addr[A10_PRECHARGE])
                                 else flag("power-up did not start with precharge-all");
                    1, 2:    assert (cmd == CMD_REFRESH)
                                 else flag("power-up refresh missing");
                    default: assert (cmd == CMD_LOAD_MODE && dram_addr == MODE_REG && dram_ba == '0)
                                 else flag("power-up mode load wrong or missing");
                endcase
                init_step++;
                if (init_step == 4) begin
                    init_seen    = 1'b1;
                    last_refresh = cyc;   // Service interval starts at the mode load
                end
            end
            case (cmd)
                CMD_PRECHARGE: begin
                    for (int b = 0; b < 4; b++) begin
                        if (dram_addr[A10_PRECHARGE] || b == int'(dram_ba)) begin
                            bank_open[b]  = 1'b0;
                            bank_ready[b] = cyc + T_RP;
                        end
                    end
                end
                CMD_REFRESH, CMD_LOAD_MODE: begin
                    assert (banks_idle(cyc)) else flag("refresh or mode load with a bank busy");
                    for (int b = 0; b < 4; b++)
                        bank_ready[b] = cyc + ((cmd == CMD_REFRESH) ? T_RC : 2);
                    if (cmd == CMD_REFRESH)
                        last_refresh = cyc;
                end
                CMD_ACTIVE: begin
                    assert (!bank_open[dram_ba] && cyc >= bank_ready[dram_ba])
                        else flag("ACTIVE before precharge or refresh recovery");
                    assert (cyc - active_at[dram_ba] >= T_RC) else flag("ACTIVE closer than tRC");
                    bank_open[dram_ba] = 1'b1;
                    active_at[dram_ba] = cyc;
                    open_row[dram_ba]  = dram_addr;
                end
                CMD_READ, CMD_WRITE: begin
                    assert (bank_open[dram_ba] && cyc - active_at[dram_ba] >= T_RCD)
                        else flag("column command closer than tRCD to its ACTIVE");
                    assert (dram_addr[A10_PRECHARGE]) else flag("column command lacks auto-precharge");
                    key  = 32'({dram_ba, open_row[dram_ba], dram_addr[9:0]});
                    word = mem.exists(key) ? mem[key] : fill_word(key);
                    if (cmd == CMD_WRITE) begin
                        if (!dram_ldqm)
                            word[7:0] = dram_dq[7:0];
                        if (!dram_udqm)
                            word[15:8] = dram_dq[15:8];
                        mem[key]            = word;
                        bank_ready[dram_ba] = cyc + T_WR + T_RP;
                    end else begin
                        rd_pending          <= 1'b1;
                        rd_wait             <= CAS_LATENCY - 1;
                        rd_word             <= word;   // Controller drops masked lanes itself
                        bank_ready[dram_ba] = cyc + 1 + T_RP;
                    end
                    bank_open[dram_ba] = 1'b0;   // Auto-precharge closes the row
                end
                default: flag("unsupported command");
            endcase
        end
        cyc++;
    end

endmodule

// File: test/sdram_controller_tb.sv
/*
 * Testbench for the SDRAM controller: drives the processor port, keeps a
 * byte-level shadow memory and checks every read against it
 */
`timescale 1ns/1ns

module sdram_controller_tb;
    import sdram_pkg::*;
    import mem_access_pkg::*;

    localparam int RANDOM_OPS      = 200;
    localparam int ACCESS_COUNT    = RANDOM_OPS + 40;   // Random plus directed accesses
    localparam int ACCESS_TIMEOUT  = 100;               // One access, refresh included
    localparam int WATCHDOG_CYCLES = INIT_WAIT_CYCLES + ACCESS_COUNT * 60;

    logic         clock;
    logic         reset;
    logic         rd_enable;
    logic         wr_enable;
    byte_addr_t   address;
    access_size_t size;
    access_data_t write_data;
    logic         busy;
    access_data_t read_data;
    logic         dram_clk;
    logic         dram_cke;
    dram_addr_t   dram_addr;
    dram_bank_t   dram_ba;
    logic         dram_cs_n;
    logic         dram_ras_n;
    logic         dram_cas_n;
    logic         dram_we_n;
    logic         dram_ldqm;
    logic         dram_udqm;
    wire  dram_data_t dram_dq;
    logic         initialized;
    logic         fault;

    logic [7:0]   shadow [byte_addr_t];   // Bytes written so far
    access_data_t held;
    byte_addr_t   base;

    sdram_controller uut (.*);
    sdram_model u_model (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    // The model reports protocol errors through fault
    initial begin
        wait (fault === 1'b1);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    task automatic report_mismatch(input string test, input access_data_t expected,
                                   input access_data_t actual);
        $display("Error: %s expected %h actual %h", test, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // Bank and row stay fixed, the byte index wraps inside the row
    function automatic byte_addr_t wrap_addr(byte_addr_t addr, int offset);
        return {addr[25:11], 11'(addr[10:0] + 11'(offset))};
    endfunction

    task automatic run_access(input string test, input logic is_write, input byte_addr_t addr,
                              input access_size_t sz, input access_data_t data,
                              input logic stray);
        access_data_t expected;
        access_data_t mask;
        int           wait_cycles;
        @(posedge clock);
        rd_enable  <= !is_write;
        wr_enable  <= is_write;
        address    <= addr;
        size       <= sz;
        write_data <= data;
        @(posedge clock);
        rd_enable <= 1'b0;
        wr_enable <= 1'b0;
        @(negedge clock);
        assert (busy) else report_failure($sformatf("%s: busy did not rise after the strobe", test));
        if (stray) begin
            @(posedge clock);
            wr_enable  <= 1'b1;                  // Lands while busy, must be dropped
            address    <= wrap_addr(addr, 64);
            write_data <= ~data;
            @(posedge clock);
            wr_enable <= 1'b0;
        end
        wait_cycles = 0;
        while (busy && wait_cycles < ACCESS_TIMEOUT) begin
            @(negedge clock);
            wait_cycles++;
        end
        assert (!busy) else report_failure($sformatf("%s: access never finished", test));
        expected = '0;
        mask     = '1;   // Bytes above the size must read as zero
        for (int i = 0; i < (1 << sz); i++) begin
            if (is_write)
                shadow[wrap_addr(addr, i)] = data[8 * i +: 8];
            else if (shadow.exists(wrap_addr(addr, i)))
                expected[8 * i +: 8] = shadow[wrap_addr(addr, i)];
            else
                mask[8 * i +: 8] = 8'h00;        // Never written, content unknown
        end
        if (!is_write)
            assert ((read_data & mask) == expected)
                else report_mismatch(test, expected, read_data & mask);
    endtask

    initial begin
        byte_addr_t addr;
        void'($urandom(25370));
        reset      = 1'b1;
        rd_enable  = 1'b0;
        wr_enable  = 1'b0;
        address    = '0;
        size       = SIZE_BYTE;
        write_data = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        // No strobe until the device has seen the whole power-up sequence
        while (!initialized) begin
            @(negedge clock);
            assert (!busy) else report_failure("busy rose during initialization");
        end

        for (int s = 0; s < 4; s++) begin
            addr = {2'd1, 13'd5, 10'd8, 1'b0} + byte_addr_t'(8 * s);
            run_access("aligned", 1'b1, addr, access_size_t'(s), {$urandom, $urandom}, 1'b0);
            run_access("aligned", 1'b0, addr, access_size_t'(s), '0, 1'b0);
        end

        // Known background, then odd-address writes of every size
        base = {2'd2, 13'd9, 10'd100, 1'b0};
        for (int k = 0; k < 3; k++)
            run_access("unaligned", 1'b1, base + byte_addr_t'(8 * k), SIZE_DOUBLE,
                       {$urandom, $urandom}, 1'b0);
        run_access("unaligned", 1'b1, base + 1, SIZE_BYTE, {$urandom, $urandom}, 1'b0);
        run_access("unaligned", 1'b1, base + 3, SIZE_HALF, {$urandom, $urandom}, 1'b0);
        run_access("unaligned", 1'b1, base + 5, SIZE_WORD, {$urandom, $urandom}, 1'b0);
        run_access("unaligned", 1'b1, base + 9, SIZE_DOUBLE, {$urandom, $urandom}, 1'b0);
        for (int k = 0; k < 3; k++)
            run_access("unaligned", 1'b0, base + byte_addr_t'(8 * k), SIZE_DOUBLE, '0, 1'b0);
        run_access("unaligned", 1'b0, base + 1, SIZE_DOUBLE, '0, 1'b0);   // Five-word read

        // Stray strobe target gets known contents first
        addr = {2'd3, 13'd77, 10'd200, 1'b0};
        run_access("stray strobe", 1'b1, wrap_addr(addr, 64), SIZE_DOUBLE,
                   {$urandom, $urandom}, 1'b0);
        run_access("stray strobe", 1'b1, addr, SIZE_DOUBLE, {$urandom, $urandom}, 1'b1);
        run_access("stray strobe", 1'b0, wrap_addr(addr, 64), SIZE_DOUBLE, '0, 1'b0);
        held = '0;
        for (int i = 0; i < 8; i++)
            held[8 * i +: 8] = shadow[wrap_addr(addr, 64 + i)];   // Bytes of the last read
        run_access("read hold", 1'b1, addr, SIZE_WORD, {$urandom, $urandom}, 1'b0);
        assert (read_data == held) else report_mismatch("read hold", held, read_data);

        // Small window at the row end so most bytes are known and columns wrap
        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr = {2'($urandom), 13'($urandom_range(0, 1)),
                    10'(1020 + $urandom_range(0, 7)), 1'($urandom)};
            run_access("random", 1'($urandom), addr, access_size_t'($urandom_range(0, 3)),
                       {$urandom, $urandom}, 1'b0);
        end

        if (fault) begin
            $display("SIMULATION FAILED");
            $fatal(1);
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: sdram_controller.f
hw/sdram_pkg.sv
hw/mem_access_pkg.sv
hw/sdram_init.sv
hw/sdram_refresh.sv
hw/sdram_read_write.sv
hw/sdram_controller.sv
test/sdram_model.sv
test/sdram_controller_tb.sv

// File: Makefile
# Verilator build, run and lint for the SDRAM controller

VERILATOR  ?= verilator
TOP        := sdram_controller_tb
RTL_TOP    := sdram_controller
FILELIST   := sdram_controller.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# $fatal in the testbench gives a nonzero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
